/* source/cache_pkg.sv */
package cache_pkg;

	// address split 5 / 8 / 3
	localparam int data_width   = 16;
	localparam int tag_width    = 5;
	localparam int index_width  = 8;
	localparam int offset_width = 3;
	localparam int num_sets     = 1 << index_width;
	localparam int line_words   = 4;

	typedef logic [data_width-1:0]   data_t;
	typedef logic [tag_width-1:0]    tag_t;
	typedef logic [index_width-1:0]  index_t;
	typedef logic [offset_width-1:0] offset_t;

	typedef struct packed {
		tag_t    tag;
		index_t  index;
		offset_t offset;
	} cache_addr_t;

	// controller to one way
	typedef struct packed {
		logic    enable;
		logic    write;
		logic    valid_in;
		logic    dirty_in;
		index_t  index;
		offset_t offset;
		tag_t    tag;
		data_t   data;
	} way_ctrl_t;

	typedef struct packed {
		logic  hit;
		logic  valid;
		logic  dirty;
		tag_t  tag;
		data_t data;
	} way_status_t;

	typedef struct packed {
		logic        rd;
		logic        wr;
		cache_addr_t addr;
		data_t       data;
	} mem_req_t;

	typedef enum logic [3:0] {
		idle,
		wb_0, wb_1, wb_2, wb_3,
		fill_0, fill_1, fill_2, fill_3, fill_4, fill_5
	} ctrl_state_e;

endpackage

/* source/cache_way.sv */
`timescale 1ns/1ps

module cache_way (
	input  logic                   clk,
	input  logic                   reset,
	input  cache_pkg::way_ctrl_t   ctrl,
	output cache_pkg::way_status_t status
);
	import cache_pkg::*;

	tag_t  tag_mem [num_sets];
	data_t data_mem [num_sets][line_words];

	logic [num_sets-1:0] valid_bits;
	logic [num_sets-1:0] dirty_bits;

	logic [1:0] word_sel;
	logic       write_en;

	// offsets 0, 2, 4, 6 map to words 0..3
	assign word_sel = ctrl.offset[2:1];
	assign write_en = ctrl.enable & ctrl.write;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (write_en)
		begin
			valid_bits[ctrl.index] <= ctrl.valid_in;
			dirty_bits[ctrl.index] <= ctrl.dirty_in;
		end
	end

	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			tag_mem[ctrl.index]            <= ctrl.tag;
			data_mem[ctrl.index][word_sel] <= ctrl.data;
		end
	end

	// lookup for whatever index the controller presents
	always_comb
	begin
		status.valid = valid_bits[ctrl.index];
		status.dirty = dirty_bits[ctrl.index];
		status.tag   = tag_mem[ctrl.index];
		status.data  = data_mem[ctrl.index][word_sel];
		status.hit   = status.valid && (status.tag == ctrl.tag);
	end

	a_write_needs_enable: assert property (@(posedge clk) disable iff (reset)
		ctrl.write |-> ctrl.enable);

endmodule

/* source/victim_select.sv */
`timescale 1ns/1ps

module victim_select (
	input  logic              clk,
	input  logic              reset,
	input  cache_pkg::index_t index,
	input  logic              valid_0,
	input  logic              valid_1,
	input  logic              touch,
	input  logic              used_way,
	output logic              victim_way
);
	import cache_pkg::*;

	// one bit per set, names the way to evict next
	logic [num_sets-1:0] lru_bits;

	always_ff @(posedge clk)
	begin
		if (reset)
			lru_bits <= '0;
		else if (touch)
			lru_bits[index] <= ~used_way;
	end

	// empty ways are filled before anything is evicted
	always_comb
	begin
		if (!valid_0)
			victim_way = 1'b0;
		else if (!valid_1)
			victim_way = 1'b1;
		else
			victim_way = lru_bits[index];
	end

endmodule

/* source/banked_memory.sv */
`timescale 1ns/1ps

module banked_memory (
	input  logic                clk,
	input  logic                reset,
	input  cache_pkg::mem_req_t req,
	output cache_pkg::data_t    mem_data
);
	import cache_pkg::*;

	localparam int bank_words = 1 << (tag_width + index_width);

	logic [1:0]                         bank_sel;
	logic [tag_width+index_width-1:0]   row;
	data_t                              bank_out [4];

	// read pipeline
	logic  s1_valid;
	logic  [1:0] s1_sel;
	logic  s2_valid;
	data_t s2_data;

	// words interleave across banks on address bits 2:1
	assign bank_sel = req.addr.offset[2:1];
	assign row      = {req.addr.tag, req.addr.index};

	for (genvar b = 0; b < 4; b++)
	begin : g_bank
		data_t mem [bank_words];
		data_t rd_q;

		always_ff @(posedge clk)
		begin
			if (req.wr && bank_sel == b)
				mem[row] <= req.data;
			if (req.rd && bank_sel == b)
				rd_q <= mem[row];
		end

		assign bank_out[b] = rd_q;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= req.rd;
			s2_valid <= s1_valid;
		end
	end

	// second stage picks the bank that was read one cycle earlier
	always_ff @(posedge clk)
	begin
		s1_sel  <= bank_sel;
		s2_data <= bank_out[s1_sel];
	end

	assign mem_data = s2_valid ? s2_data : '0;

	a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(req.rd && req.wr));

endmodule

/* source/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rd,
	input  logic                   wr,
	input  cache_pkg::cache_addr_t addr,
	input  cache_pkg::data_t       write_data,
	input  cache_pkg::way_status_t status_0,
	input  cache_pkg::way_status_t status_1,
	input  logic                   victim_way,
	input  cache_pkg::data_t       mem_data,
	output cache_pkg::way_ctrl_t   ctrl_0,
	output cache_pkg::way_ctrl_t   ctrl_1,
	output cache_pkg::mem_req_t    mem_req,
	output logic                   touch,
	output logic                   used_way,
	output cache_pkg::data_t       read_data,
	output logic                   done,
	output logic                   stall,
	output logic                   cache_hit
);
	import cache_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;

	logic        req;
	logic        hit_any;
	logic        victim_q;
	logic        write_q;
	logic        sel_way;
	logic        target_way;
	way_status_t victim_status;
	way_ctrl_t   way_cmd;
	data_t       read_latch;

	// per-state step decode
	logic       wb_active;
	logic       rd_issue;
	logic       fill_write;
	logic [1:0] wb_word;
	logic [1:0] rd_word;
	logic [1:0] fill_word;
	logic       req_word_match;

	assign req     = rd | wr;
	assign hit_any = status_0.hit | status_1.hit;

	// selector in idle and the registered choice after
	assign sel_way       = (state == idle) ? victim_way : victim_q;
	assign victim_status = sel_way ? status_1 : status_0;

	assign req_word_match = (fill_word == addr.offset[2:1]);

	always_comb
	begin
		wb_active  = 1'b0;
		rd_issue   = 1'b0;
		fill_write = 1'b0;
		wb_word    = 2'd0;
		rd_word    = 2'd0;
		fill_word  = 2'd0;
		unique case (state)
			wb_0:
			begin
				wb_active = 1'b1;
				wb_word   = 2'd0;
			end
			wb_1:
			begin
				wb_active = 1'b1;
				wb_word   = 2'd1;
			end
			wb_2:
			begin
				wb_active = 1'b1;
				wb_word   = 2'd2;
			end
			wb_3:
			begin
				wb_active = 1'b1;
				wb_word   = 2'd3;
			end
			fill_0:
			begin
				rd_issue = 1'b1;
				rd_word  = 2'd0;
			end
			fill_1:
			begin
				rd_issue = 1'b1;
				rd_word  = 2'd1;
			end
			// reads from fill_0 come back two cycles on
			fill_2:
			begin
				rd_issue   = 1'b1;
				rd_word    = 2'd2;
				fill_write = 1'b1;
				fill_word  = 2'd0;
			end
			fill_3:
			begin
				rd_issue   = 1'b1;
				rd_word    = 2'd3;
				fill_write = 1'b1;
				fill_word  = 2'd1;
			end
			fill_4:
			begin
				fill_write = 1'b1;
				fill_word  = 2'd2;
			end
			fill_5:
			begin
				fill_write = 1'b1;
				fill_word  = 2'd3;
			end
			default: ;
		endcase
	end

	always_comb
	begin
		next_state = state;
		unique case (state)
			idle:
			begin
				if (req && !hit_any)
					next_state = (victim_status.valid && victim_status.dirty) ? wb_0 : fill_0;
			end
			wb_0:    next_state = wb_1;
			wb_1:    next_state = wb_2;
			wb_2:    next_state = wb_3;
			wb_3:    next_state = fill_0;
			fill_0:  next_state = fill_1;
			fill_1:  next_state = fill_2;
			fill_2:  next_state = fill_3;
			fill_3:  next_state = fill_4;
			fill_4:  next_state = fill_5;
			fill_5:  next_state = idle;
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= idle;
			victim_q <= 1'b0;
			write_q  <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == idle && req && !hit_any)
			begin
				victim_q <= victim_way;
				write_q  <= wr;
			end
		end
	end

	// requested word as it streams past
	always_ff @(posedge clk)
	begin
		if (fill_write && !write_q && req_word_match)
			read_latch <= mem_data;
	end

	always_comb
	begin
		way_cmd          = '0;
		way_cmd.index    = addr.index;
		way_cmd.offset   = addr.offset;
		way_cmd.tag      = addr.tag;
		way_cmd.data     = write_data;
		way_cmd.valid_in = 1'b1;
		way_cmd.dirty_in = 1'b1;
		target_way       = victim_q;
		mem_req          = '0;
		mem_req.addr     = addr;
		touch            = 1'b0;
		used_way         = victim_q;
		read_data        = read_latch;
		done             = 1'b0;
		cache_hit        = 1'b0;
		stall            = 1'b1;

		if (state == idle)
		begin
			target_way     = status_1.hit;
			way_cmd.enable = req & hit_any;
			way_cmd.write  = wr & hit_any;
			read_data      = status_1.hit ? status_1.data : status_0.data;
			done           = req & hit_any;
			cache_hit      = req & hit_any;
			touch          = req & hit_any;
			used_way       = status_1.hit;
			stall          = req & ~hit_any;
		end

		// victim line out to memory under its stored tag
		if (wb_active)
		begin
			way_cmd.enable      = 1'b1;
			way_cmd.offset      = {wb_word, 1'b0};
			mem_req.wr          = 1'b1;
			mem_req.addr.tag    = victim_status.tag;
			mem_req.addr.offset = {wb_word, 1'b0};
			mem_req.data        = victim_status.data;
		end

		if (rd_issue)
		begin
			mem_req.rd          = 1'b1;
			mem_req.addr.offset = {rd_word, 1'b0};
		end

		// write miss merges its data into the refilled word
		if (fill_write)
		begin
			way_cmd.enable   = 1'b1;
			way_cmd.write    = 1'b1;
			way_cmd.offset   = {fill_word, 1'b0};
			way_cmd.dirty_in = write_q;
			way_cmd.data     = (write_q && req_word_match) ? write_data : mem_data;
		end

		if (state == fill_5)
		begin
			done      = 1'b1;
			touch     = 1'b1;
			stall     = 1'b0;
			read_data = req_word_match ? mem_data : read_latch;
		end
	end

	always_comb
	begin
		ctrl_0        = way_cmd;
		ctrl_1        = way_cmd;
		ctrl_0.enable = way_cmd.enable & ~target_way;
		ctrl_0.write  = way_cmd.write & ~target_way;
		ctrl_1.enable = way_cmd.enable & target_way;
		ctrl_1.write  = way_cmd.write & target_way;
	end

	a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(rd && wr));

	// done only from a single-way hit in idle or the last refill step
	a_done_state: assert property (@(posedge clk) disable iff (reset)
		done |-> (state == fill_5 || (state == idle && (status_0.hit ^ status_1.hit))));

endmodule

/* source/cache_system.sv */
`timescale 1ns/1ps

module cache_system (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rd,
	input  logic                   wr,
	input  cache_pkg::cache_addr_t addr,
	input  cache_pkg::data_t       write_data,
	output cache_pkg::data_t       read_data,
	output logic                   done,
	output logic                   stall,
	output logic                   cache_hit
);
	import cache_pkg::*;

	way_ctrl_t   ctrl_0;
	way_ctrl_t   ctrl_1;
	way_status_t status_0;
	way_status_t status_1;
	mem_req_t    mem_req;
	data_t       mem_data;
	logic        victim_way;
	logic        touch;
	logic        used_way;

	cache_controller u_controller (
		.clk        (clk),
		.reset      (reset),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.write_data (write_data),
		.status_0   (status_0),
		.status_1   (status_1),
		.victim_way (victim_way),
		.mem_data   (mem_data),
		.ctrl_0     (ctrl_0),
		.ctrl_1     (ctrl_1),
		.mem_req    (mem_req),
		.touch      (touch),
		.used_way   (used_way),
		.read_data  (read_data),
		.done       (done),
		.stall      (stall),
		.cache_hit  (cache_hit)
	);

	cache_way u_way_0 (
		.clk    (clk),
		.reset  (reset),
		.ctrl   (ctrl_0),
		.status (status_0)
	);

	cache_way u_way_1 (
		.clk    (clk),
		.reset  (reset),
		.ctrl   (ctrl_1),
		.status (status_1)
	);

	// victim choice follows the requested set
	victim_select u_victim (
		.clk        (clk),
		.reset      (reset),
		.index      (addr.index),
		.valid_0    (status_0.valid),
		.valid_1    (status_1.valid),
		.touch      (touch),
		.used_way   (used_way),
		.victim_way (victim_way)
	);

	banked_memory u_memory (
		.clk      (clk),
		.reset    (reset),
		.req      (mem_req),
		.mem_data (mem_data)
	);

endmodule

/* verification/tb_cache_system.sv */
`timescale 1ns/1ps

module tb_cache_system;
	import cache_pkg::*;

	logic        clk;
	logic        reset;
	logic        rd;
	logic        wr;
	cache_addr_t addr;
	data_t       write_data;
	data_t       read_data;
	logic        done;
	logic        stall;
	logic        cache_hit;

	// word model by byte address and set model per way
	data_t       word_model [int];
	tag_t        model_tag [2][num_sets];
	logic        model_valid [2][num_sets];
	logic        model_dirty [2][num_sets];
	logic        model_lru [num_sets];
	cache_addr_t written_q [$];

	logic [31:0] lfsr_state;
	string       test_name;
	int          test_errors;
	int          total_errors;
	int          tests_passed;
	int          tests_failed;

	cache_system dut (
		.clk        (clk),
		.reset      (reset),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.write_data (write_data),
		.read_data  (read_data),
		.done       (done),
		.stall      (stall),
		.cache_hit  (cache_hit)
	);

	always #20 clk = ~clk;

	// right-shifting Galois form with taps 32 31 29 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hd000_0001;
		return s >> 1;
	endfunction

	function automatic logic [15:0] take_bits(input int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	task automatic check_data(input string what, input data_t expected, input data_t actual);
		if (actual !== expected)
		begin
			$display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_hit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("mismatch %s %s: expected %b actual %b", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_latency(input string what, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("mismatch %s %s: expected %0d actual %0d", test_name, what, expected,
				actual);
			test_errors++;
		end
	endtask

	// invalid way first, then the LRU way; a dirty valid victim costs a write-back
	task automatic predict_access(input cache_addr_t a, input logic is_write,
		output logic exp_hit, output int exp_cycles);
		int way;
		int victim;
		way = -1;
		for (int w = 0; w < 2; w++)
			if (model_valid[w][a.index] && model_tag[w][a.index] == a.tag)
				way = w;
		if (way >= 0)
		begin
			exp_hit = 1'b1;
			exp_cycles = 0;
			if (is_write)
				model_dirty[way][a.index] = 1'b1;
			model_lru[a.index] = (way == 0);
		end
		else
		begin
			if (!model_valid[0][a.index])
				victim = 0;
			else if (!model_valid[1][a.index])
				victim = 1;
			else
				victim = model_lru[a.index];
			exp_hit = 1'b0;
			exp_cycles = (model_valid[victim][a.index] && model_dirty[victim][a.index]) ? 10 : 6;
			model_tag[victim][a.index] = a.tag;
			model_valid[victim][a.index] = 1'b1;
			model_dirty[victim][a.index] = is_write;
			model_lru[a.index] = (victim == 0);
		end
	endtask

	task automatic access(input logic is_write, input cache_addr_t a, input data_t wdata);
		int    cycles;
		int    exp_cycles;
		logic  seen;
		logic  exp_hit;
		logic  got_hit;
		data_t got_data;
		predict_access(a, is_write, exp_hit, exp_cycles);
		@(posedge clk);
		rd <= !is_write;
		wr <= is_write;
		addr <= a;
		write_data <= wdata;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles <= 20)
		begin
			@(negedge clk);
			if (done)
			begin
				seen = 1'b1;
				got_data = read_data;
				got_hit = cache_hit;
				check_hit("stall at done", 1'b0, stall);
			end
			else
			begin
				check_hit("stall while pending", 1'b1, stall);
				cycles++;
			end
		end
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		if (!seen)
		begin
			$display("%s: done never came within 20 cycles for address %h", test_name, a);
			$display("STATUS: FAIL");
			$finish;
		end
		else
		begin
			check_hit("cache_hit", exp_hit, got_hit);
			check_latency("cycles to done", exp_cycles, cycles);
			if (is_write)
			begin
				if (!word_model.exists(int'(a)))
					written_q.push_back(a);
				word_model[int'(a)] = wdata;
			end
			else
				check_data("read_data", word_model[int'(a)], got_data);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0)
		begin
			$display("test %s: ok", test_name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: %0d errors", test_name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
	endtask

	task automatic test_idle_outputs();
		start_test("idle_outputs");
		for (int i = 0; i < 5; i++)
		begin
			@(negedge clk);
			check_hit("done", 1'b0, done);
			check_hit("stall", 1'b0, stall);
			check_hit("cache_hit", 1'b0, cache_hit);
		end
		finish_test();
	endtask

	task automatic test_cold_write();
		start_test("cold_write_then_read");
		access(1'b1, '{tag: 5'h03, index: 8'h12, offset: 3'd4}, 16'h5a3c);
		access(1'b0, '{tag: 5'h03, index: 8'h12, offset: 3'd4}, 16'h0000);
		finish_test();
	endtask

	task automatic test_two_ways();
		start_test("two_ways_resident");
		access(1'b1, '{tag: 5'h01, index: 8'h33, offset: 3'd2}, 16'h1111);
		access(1'b1, '{tag: 5'h02, index: 8'h33, offset: 3'd6}, 16'h2222);
		for (int i = 0; i < 2; i++)
		begin
			access(1'b0, '{tag: 5'h01, index: 8'h33, offset: 3'd2}, 16'h0000);
			access(1'b0, '{tag: 5'h02, index: 8'h33, offset: 3'd6}, 16'h0000);
		end
		finish_test();
	endtask

	// tag 1 is least recently used and dirty here
	task automatic test_eviction();
		start_test("dirty_eviction");
		access(1'b1, '{tag: 5'h04, index: 8'h33, offset: 3'd0}, 16'h3c3c);
		access(1'b0, '{tag: 5'h01, index: 8'h33, offset: 3'd2}, 16'h0000);
		access(1'b0, '{tag: 5'h04, index: 8'h33, offset: 3'd0}, 16'h0000);
		finish_test();
	endtask

	task automatic test_random_mix();
		cache_addr_t a;
		int          pick;
		logic [15:0] draw;
		start_test("random_mix");
		for (int n = 0; n < 200; n++)
		begin
			if (take_bits(1) && written_q.size() > 0)
			begin
				pick = take_bits(8) % written_q.size();
				access(1'b0, written_q[pick], 16'h0000);
			end
			else
			begin
				draw = take_bits(2);
				a.index = 8'h80 + draw[1:0];
				draw = take_bits(2);
				a.tag = {3'b000, draw[1:0]};
				draw = take_bits(2);
				a.offset = {draw[1:0], 1'b0};
				access(1'b1, a, take_bits(16));
			end
		end
		finish_test();
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		write_data = '0;
		lfsr_state = 32'hcab9_ad4d;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int s = 0; s < num_sets; s++)
		begin
			model_valid[0][s] = 1'b0;
			model_valid[1][s] = 1'b0;
			model_dirty[0][s] = 1'b0;
			model_dirty[1][s] = 1'b0;
			model_lru[s] = 1'b0;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		test_idle_outputs();
		test_cold_write();
		test_two_ways();
		test_eviction();
		test_random_mix();

		$display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* filelist.f */
source/cache_pkg.sv
source/cache_way.sv
source/victim_select.sv
source/banked_memory.sv
source/cache_controller.sv
source/cache_system.sv
verification/tb_cache_system.sv

/* Bender.yml */
package:
  name: cache_system

sources:
  - files:
      - source/cache_pkg.sv
      - source/cache_way.sv
      - source/victim_select.sv
      - source/banked_memory.sv
      - source/cache_controller.sv
      - source/cache_system.sv
  - target: test
    files:
      - verification/tb_cache_system.sv
